//--- all.f
+incdir+.
ldst_cmd_pkg.sv
mem_bus_pkg.sv
line_addr_gen.sv
line_buffer.sv
rf_ram.sv
ldst_ctrl.sv
rf_ldst_top.sv
tb_sdram_model.sv
tb_rf_ldst.sv

//--- Bender.yml
package:
  name: rf_ldst

sources:
  - include_dirs:
      - .
    files:
      - ldst_cmd_pkg.sv
      - mem_bus_pkg.sv
      - line_addr_gen.sv
      - line_buffer.sv
      - rf_ram.sv
      - ldst_ctrl.sv
      - rf_ldst_top.sv
      - target: test
        files:
          - tb_sdram_model.sv
          - tb_rf_ldst.sv

//--- ldst_input.txt
# op sdram_addr rf_row line_cnt last_burst_addr, all hex
# op 0 is a load (SDRAM to RF), op 1 is a store (RF to SDRAM)
0 0100 3 01 0100
1 2000 3 01 2000
0 0400 0 10 04f0
1 1000 0 10 10f0
0 0800 5 04 0830
1 3000 5 04 3030
0 0a00 e 03 0a20
1 3800 e 03 3820
1 0200 2 02 0210
0 1200 8 02 1210
1 3f00 8 02 3f10
0 0000 c 01 0000
1 3400 c 01 3400

//--- tb_rf_ldst.sv
// Testbench for the line mover; commands must load an RF row before any store reads it
`timescale 1ns/1ns

`include "ldst_defs.svh"

module tb_rf_ldst;

    localparam int MAX_CMDS = 64;
    localparam int TIMEOUT  = 4000;  // Cycles per wait

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      cmd_valid;
    ldst_cmd_pkg::ldst_cmd_t   cmd;
    mem_bus_pkg::sdram_rsp_t   sdram_rsp;
    logic                      cmd_ready;
    mem_bus_pkg::sdram_req_t   sdram_req;

    logic        op_list   [MAX_CMDS];
    logic [15:0] addr_list [MAX_CMDS];
    logic [3:0]  row_list  [MAX_CMDS];
    logic [4:0]  cnt_list  [MAX_CMDS];
    logic [15:0] last_list [MAX_CMDS];  // Expected address of the last burst
    int          n_cmds;

    logic [31:0]  ref_mem [4096];
    logic [127:0] ref_rf  [16];
    logic [15:0]  obs_addr [$];
    bit           obs_store [$];

    bit          in_burst;
    int          beats;
    logic [15:0] burst_addr;

    always #5 clk = ~clk;

    rf_ldst_top DUT (
        .clk, .rst_n, .cmd_valid, .cmd, .sdram_rsp, .cmd_ready, .sdram_req
    );

    tb_sdram_model u_sdram (.clk, .rst_n, .req (sdram_req), .rsp (sdram_rsp));

    task automatic stop_on_error();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic int word_index(input logic [15:0] byte_addr, input int beat);
        return ((byte_addr >> 2) + beat) % 4096;
    endfunction

    ////////////////////////////////////////////////////////////
    // Burst monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n) begin
            if (sdram_req.read_start || sdram_req.write_start) begin
                assert (!in_burst) else begin
                    $display("Burst start seen while a burst was still open");
                    stop_on_error();
                end
                in_burst   = 1'b1;
                beats      = 0;
                burst_addr = sdram_req.addr;
                obs_addr.push_back(sdram_req.addr);
                obs_store.push_back(sdram_req.write_start);
            end else if (in_burst) begin
                if (sdram_rsp.read_valid || sdram_rsp.write_nxt) begin
                    beats++;
                    assert (sdram_req.addr == burst_addr) else begin
                        $display("Fail sdram_req.addr got %h expected %h",
                                 sdram_req.addr, burst_addr);
                        stop_on_error();
                    end
                end
                if (sdram_rsp.rw_done) begin
                    assert (beats == `LDST_BEATS) else begin
                        $display("Fail burst beats got %h expected %h", beats, `LDST_BEATS);
                        stop_on_error();
                    end
                    in_burst = 1'b0;
                end
            end
        end
    end

    task automatic read_commands();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op, f_addr, f_row, f_cnt, f_last;
        fd = $fopen("ldst_input.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the command file ldst_input.txt");
            stop_on_error();
        end
        n_cmds = 0;
        while (!$feof(fd) && n_cmds < MAX_CMDS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_row, f_cnt, f_last);
            if (n == 5) begin
                op_list[n_cmds]   = f_op[0];
                addr_list[n_cmds] = f_addr[15:0];
                row_list[n_cmds]  = f_row[3:0];
                cnt_list[n_cmds]  = f_cnt[4:0];
                last_list[n_cmds] = f_last[15:0];
                n_cmds++;
            end
        end
        $fclose(fd);
    endtask

    // Line rules: stride of 16 bytes, consecutive rows, beat 0 in the low bits
    task automatic apply_to_reference(input int i);
        logic [3:0]  r;
        logic [15:0] base;
        for (int l = 0; l < cnt_list[i]; l++) begin
            r    = row_list[i] + l;
            base = addr_list[i] + 16 * l;
            for (int b = 0; b < 4; b++) begin
                if (op_list[i])
                    ref_mem[word_index(base, b)] = ref_rf[r][b*32 +: 32];
                else
                    ref_rf[r][b*32 +: 32] = ref_mem[word_index(base, b)];
            end
        end
    endtask

    task automatic send_command(input int i);
        int waited;
        @(negedge clk);
        if (i > 0) begin
            assert (cmd_ready == 1'b0) else begin  // Previous command still busy
                $display("Fail cmd_ready got %h expected %h", cmd_ready, 1'b0);
                stop_on_error();
            end
        end
        cmd_valid      = 1'b1;
        cmd.op         = ldst_cmd_pkg::ldst_op_e'(op_list[i]);
        cmd.sdram_addr = addr_list[i];
        cmd.rf_row     = row_list[i];
        cmd.line_cnt   = cnt_list[i];
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited <= TIMEOUT) else begin
                $display("Timed out waiting for command %0d to be accepted", i);
                stop_on_error();
            end
        end while (!cmd_ready);
        apply_to_reference(i);
    endtask

    task automatic wait_for_idle();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited <= TIMEOUT) else begin
                $display("Timed out waiting for the engine to return to idle");
                stop_on_error();
            end
        end while (!cmd_ready);
    endtask

    task automatic check_bursts();
        int          k;
        int          total;
        logic [15:0] exp_addr;
        total = 0;
        for (int i = 0; i < n_cmds; i++)
            total += cnt_list[i];
        assert (obs_addr.size() == total) else begin
            $display("Fail burst_count got %h expected %h", obs_addr.size(), total);
            stop_on_error();
        end
        k = 0;
        for (int i = 0; i < n_cmds; i++) begin
            for (int l = 0; l < cnt_list[i]; l++) begin
                exp_addr = addr_list[i] + 16 * l;
                assert (obs_addr[k] == exp_addr) else begin
                    $display("Fail sdram_req.addr got %h expected %h", obs_addr[k], exp_addr);
                    stop_on_error();
                end
                assert (obs_store[k] == op_list[i]) else begin
                    $display("Fail sdram_req.write_start got %h expected %h",
                             obs_store[k], op_list[i]);
                    stop_on_error();
                end
                if (l == cnt_list[i] - 1) begin
                    assert (obs_addr[k] == last_list[i]) else begin
                        $display("Fail last sdram_req.addr got %h expected %h",
                                 obs_addr[k], last_list[i]);
                        stop_on_error();
                    end
                end
                k++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        in_burst   = 1'b0;
        beats      = 0;
        burst_addr = '0;
        read_commands();
        #1;
        for (int w = 0; w < 4096; w++)
            ref_mem[w] = u_sdram.mem[w];  // Same start contents as the model
        repeat (4) begin
            @(negedge clk);
            assert (cmd_ready && !sdram_req.read_start && !sdram_req.write_start) else begin
                $display("Fail {cmd_ready,read_start,write_start} got %h expected %h",
                         {cmd_ready, sdram_req.read_start, sdram_req.write_start}, 3'b100);
                stop_on_error();
            end
        end
        rst_n = 1'b1;
        @(negedge clk);
        assert (cmd_ready && !sdram_req.read_start && !sdram_req.write_start) else begin
            $display("Fail {cmd_ready,read_start,write_start} got %h expected %h",
                     {cmd_ready, sdram_req.read_start, sdram_req.write_start}, 3'b100);
            stop_on_error();
        end
        for (int i = 0; i < n_cmds; i++)
            send_command(i);
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_for_idle();
        check_bursts();
        for (int w = 0; w < 4096; w++) begin
            assert (u_sdram.mem[w] === ref_mem[w]) else begin
                $display("Fail sdram word %h got %h expected %h", w, u_sdram.mem[w], ref_mem[w]);
                stop_on_error();
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
// SDRAM model for the testbench; decodes byte address bits 13:2 only, so 4096 words
`timescale 1ns/1ns

`include "ldst_defs.svh"

module tb_sdram_model (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_bus_pkg::sdram_req_t   req,
    output mem_bus_pkg::sdram_rsp_t   rsp
);

    logic [31:0] mem [4096];
    logic [31:0] rnd;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_stall(output int n);
        rnd = xorshift32(rnd);
        n   = rnd[1:0];  // 0 to 3 cycles
    endtask

    function automatic int word_of(input logic [15:0] byte_addr, input int beat);
        return ((byte_addr >> 2) + beat) % 4096;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bursts, driven on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic run_burst(input logic [15:0] addr, input bit is_write);
        int stall;
        int extra;
        next_stall(extra);  // Nonzero puts rw_done after the last beat
        for (int b = 0; b < `LDST_BEATS; b++) begin
            next_stall(stall);
            repeat (stall) begin
                @(negedge clk);
                rsp = '0;
            end
            @(negedge clk);
            rsp = '0;
            if (is_write) begin
                rsp.write_nxt = 1'b1;
                mem[word_of(addr, b)] = req.write_data;
            end else begin
                rsp.read_valid = 1'b1;
                rsp.read_data  = mem[word_of(addr, b)];
            end
            rsp.rw_done = (b == `LDST_BEATS - 1) && (extra == 0);
        end
        @(negedge clk);
        rsp = '0;
        if (extra != 0) begin
            repeat (extra - 1) @(negedge clk);
            rsp.rw_done = 1'b1;
            @(negedge clk);
            rsp = '0;
        end
    endtask

    initial begin
        rnd = 32'h31b0_4a7a;
        for (int w = 0; w < 4096; w++) begin
            rnd    = xorshift32(rnd);
            mem[w] = rnd ^ w;
        end
        rsp = '0;
        forever begin
            @(posedge clk);
            if (rst_n && req.read_start)       run_burst(req.addr, 1'b0);
            else if (rst_n && req.write_start) run_burst(req.addr, 1'b1);
        end
    end

endmodule

//--- rf_ldst_top.sv
// Line mover top; cmd must stay stable while cmd_valid is high and cmd_ready is low
`timescale 1ns/1ns

`include "ldst_defs.svh"

module rf_ldst_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  ldst_cmd_pkg::ldst_cmd_t    cmd,
    input  mem_bus_pkg::sdram_rsp_t    sdram_rsp,
    output logic                       cmd_ready,
    output mem_bus_pkg::sdram_req_t    sdram_req
);

    logic read_start, write_start, rf_we, rf_re;
    logic addr_clr, addr_nxt, last_line;
    logic ld_beat, ld_line, idx_inc, idx_clr;

    logic [`LDST_SDRAM_ADDR_W-1:0] sdram_addr;
    logic [`LDST_RF_ADDR_W-1:0]    rf_row;
    logic [`LDST_BEAT_W-1:0]       beat_out;
    logic [`LDST_LINE_W-1:0]       line_out;
    logic [`LDST_LINE_W-1:0]       rf_q;
    mem_bus_pkg::rf_req_t          rf_req;

    ////////////////////////////////////////////////////////////
    // Control and datapath
    ////////////////////////////////////////////////////////////
    ldst_ctrl u_ctrl (
        .clk, .rst_n, .cmd_valid,
        .op (cmd.op), .rsp (sdram_rsp), .last_line,
        .cmd_ready, .read_start, .write_start, .rf_we, .rf_re,
        .addr_clr, .addr_nxt, .ld_beat, .ld_line, .idx_inc, .idx_clr
    );

    line_addr_gen u_addr (
        .clk, .rst_n, .clr (addr_clr), .nxt (addr_nxt), .cmd,
        .sdram_addr, .rf_row, .last_line
    );

    line_buffer u_buf (
        .clk, .rst_n, .ld_beat, .ld_line, .idx_inc, .idx_clr,
        .beat_in (sdram_rsp.read_data), .line_in (rf_q),
        .beat_out, .line_out
    );

    rf_ram u_rf (.clk, .rst_n, .req (rf_req), .q (rf_q));

    // Request structs
    assign sdram_req.read_start  = read_start;
    assign sdram_req.write_start = write_start;
    assign sdram_req.addr        = sdram_addr;
    assign sdram_req.write_data  = beat_out;

    assign rf_req.we   = rf_we;
    assign rf_req.re   = rf_re;
    assign rf_req.addr = rf_row;
    assign rf_req.data = line_out;

    a_cmd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd_ready |-> cmd.line_cnt != '0);

endmodule

//--- ldst_ctrl.sv
// One line in flight; SDRAM side must not take a write beat in the write_start cycle
`timescale 1ns/1ns

module ldst_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  ldst_cmd_pkg::ldst_op_e    op,
    input  mem_bus_pkg::sdram_rsp_t   rsp,
    input  logic                      last_line,
    output logic                      cmd_ready,
    output logic                      read_start,
    output logic                      write_start,
    output logic                      rf_we,
    output logic                      rf_re,
    output logic                      addr_clr,
    output logic                      addr_nxt,
    output logic                      ld_beat,
    output logic                      ld_line,
    output logic                      idx_inc,
    output logic                      idx_clr
);

    typedef enum logic [2:0] {
        IDLE,
        SDRAM_RD,
        RF_WR,
        RF_RD,
        SDRAM_WR
    } state_t;

    state_t state, state_nxt;
    logic   start_pend;  // First cycle of a follow-on burst

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            start_pend <= 1'b0;
        end else begin
            state      <= state_nxt;
            start_pend <= (state == RF_WR && !last_line) || (state == RF_RD);
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobes and next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        cmd_ready   = 1'b0;
        read_start  = 1'b0;
        write_start = 1'b0;
        rf_we       = 1'b0;
        rf_re       = 1'b0;
        addr_clr    = 1'b0;
        addr_nxt    = 1'b0;
        ld_beat     = 1'b0;
        ld_line     = 1'b0;
        idx_inc     = 1'b0;
        idx_clr     = 1'b0;
        state_nxt   = state;

        case (state)
            IDLE: begin
                cmd_ready = 1'b1;
                addr_clr  = 1'b1;   // Track the offered command
                idx_clr   = 1'b1;
                if (cmd_valid) begin
                    if (op == ldst_cmd_pkg::OP_LOAD) begin
                        read_start = 1'b1;  // First burst in the accept cycle
                        state_nxt  = SDRAM_RD;
                    end else begin
                        state_nxt  = RF_RD;
                    end
                end
            end

            SDRAM_RD: begin
                read_start = start_pend;
                if (rsp.read_valid) begin
                    ld_beat = 1'b1;
                    idx_inc = 1'b1;
                end
                // Last beat may land with rw_done, so the RF write waits a cycle
                if (rsp.rw_done)
                    state_nxt = RF_WR;
            end

            RF_WR: begin
                rf_we     = 1'b1;
                addr_nxt  = 1'b1;
                idx_clr   = 1'b1;
                state_nxt = last_line ? IDLE : SDRAM_RD;
            end

            RF_RD: begin
                rf_re     = 1'b1;  // Row comes back next cycle
                state_nxt = SDRAM_WR;
            end

            SDRAM_WR: begin
                if (start_pend) begin
                    write_start = 1'b1;
                    ld_line     = 1'b1;
                    idx_clr     = 1'b1;
                end
                if (rsp.write_nxt)
                    idx_inc = 1'b1;
                if (rsp.rw_done) begin
                    addr_nxt  = 1'b1;  // Address held until the burst is over
                    state_nxt = last_line ? IDLE : RF_RD;
                end
            end

            default: state_nxt = IDLE;
        endcase
    end

    a_rd_beat_state: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.read_valid |-> state == SDRAM_RD);

    a_wr_start_beat: assert property (@(posedge clk) disable iff (!rst_n)
        write_start |-> !rsp.write_nxt);

endmodule

//--- rf_ram.sv
// Single-port RF RAM; read data is valid the cycle after re, contents undefined after reset
`timescale 1ns/1ns

`include "ldst_defs.svh"

module rf_ram (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_bus_pkg::rf_req_t      req,
    output logic [`LDST_LINE_W-1:0]   q
);

    logic [`LDST_LINE_W-1:0] mem [`LDST_RF_ROWS];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req.we)
            mem[req.addr] <= req.data;
    end

    ////////////////////////////////////////////////////////////
    // Registered read
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req.re)
            q <= mem[req.addr];  // Holds until the next read
    end

    // One port, so the controller must never ask for both
    a_we_re: assert property (@(posedge clk) disable iff (!rst_n) !(req.we && req.re));

endmodule

//--- line_buffer.sv
// One line of LDST_BEATS beats; the index wraps, so a full burst leaves it at zero
`timescale 1ns/1ns

`include "ldst_defs.svh"

module line_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ld_beat,
    input  logic                      ld_line,
    input  logic                      idx_inc,
    input  logic                      idx_clr,
    input  logic [`LDST_BEAT_W-1:0]   beat_in,
    input  logic [`LDST_LINE_W-1:0]   line_in,
    output logic [`LDST_BEAT_W-1:0]   beat_out,
    output logic [`LDST_LINE_W-1:0]   line_out
);

    localparam int IDX_W = $clog2(`LDST_BEATS);

    logic [`LDST_BEAT_W-1:0] beats [`LDST_BEATS];
    logic [IDX_W-1:0]        idx;

    ////////////////////////////////////////////////////////////
    // Beat index
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)       idx <= '0;
        else if (idx_clr) idx <= '0;   // Clear wins over increment
        else if (idx_inc) idx <= idx + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Beat storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (ld_line) begin
            for (int b = 0; b < `LDST_BEATS; b++)
                beats[b] <= line_in[b*`LDST_BEAT_W +: `LDST_BEAT_W];
        end else if (ld_beat) begin
            beats[idx] <= beat_in;
        end
    end

    // Beat 0 in the low bits
    always_comb begin
        for (int b = 0; b < `LDST_BEATS; b++)
            line_out[b*`LDST_BEAT_W +: `LDST_BEAT_W] = beats[b];
    end

    assign beat_out = beats[idx];

    a_one_load: assert property (@(posedge clk) disable iff (!rst_n) !(ld_beat && ld_line));

endmodule

//--- line_addr_gen.sv
// Outputs follow cmd directly while clr is high; the RF row wraps modulo LDST_RF_ROWS
`timescale 1ns/1ns

`include "ldst_defs.svh"

module line_addr_gen (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            clr,
    input  logic                            nxt,
    input  ldst_cmd_pkg::ldst_cmd_t         cmd,
    output logic [`LDST_SDRAM_ADDR_W-1:0]   sdram_addr,
    output logic [`LDST_RF_ADDR_W-1:0]      rf_row,
    output logic                            last_line
);

    localparam logic [`LDST_SDRAM_ADDR_W-1:0] STRIDE   = `LDST_LINE_STRIDE;
    localparam logic [`LDST_CNT_W-1:0]        ONE_LEFT = 1;

    logic [`LDST_SDRAM_ADDR_W-1:0] addr_q;
    logic [`LDST_RF_ADDR_W-1:0]    row_q;
    logic [`LDST_CNT_W-1:0]        cnt_q;   // Lines still to move

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            row_q  <= '0;
            cnt_q  <= '0;
        end else if (clr) begin
            addr_q <= cmd.sdram_addr;
            row_q  <= cmd.rf_row;
            cnt_q  <= cmd.line_cnt;
        end else if (nxt) begin
            addr_q <= addr_q + STRIDE;
            row_q  <= row_q + 1'b1;
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    // Lets a burst start in the same cycle the command is taken
    assign sdram_addr = clr ? cmd.sdram_addr : addr_q;
    assign rf_row     = clr ? cmd.rf_row : row_q;
    assign last_line  = (cnt_q == ONE_LEFT);  // The step taken now leaves zero

    // Controller must stop stepping once the command is used up
    a_nxt_cnt: assert property (@(posedge clk) disable iff (!rst_n) nxt |-> cnt_q != '0);

endmodule

//--- mem_bus_pkg.sv
// Memory-side bus types; SDRAM bursts are always LDST_BEATS beats, so no count field
`include "ldst_defs.svh"

package mem_bus_pkg;

    ////////////////////////////////////////////////////////////
    // SDRAM port
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                            read_start;   // One-cycle pulse
        logic                            write_start;  // One-cycle pulse
        logic [`LDST_SDRAM_ADDR_W-1:0]   addr;         // Held for the burst
        logic [`LDST_BEAT_W-1:0]         write_data;
    } sdram_req_t;

    typedef struct packed {
        logic                            read_valid;
        logic [`LDST_BEAT_W-1:0]         read_data;
        logic                            write_nxt;    // Beat taken
        logic                            rw_done;      // End of burst
    } sdram_rsp_t;

    ////////////////////////////////////////////////////////////
    // RF RAM port
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                            we;
        logic                            re;
        logic [`LDST_RF_ADDR_W-1:0]      addr;
        logic [`LDST_LINE_W-1:0]         data;
    } rf_req_t;

endpackage

//--- ldst_cmd_pkg.sv
// Command types only; a command with line_cnt of zero is illegal
`include "ldst_defs.svh"

package ldst_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // Operation code
    ////////////////////////////////////////////////////////////
    typedef enum logic {
        OP_LOAD  = 1'b0,  // SDRAM to RF
        OP_STORE = 1'b1   // RF to SDRAM
    } ldst_op_e;

    ////////////////////////////////////////////////////////////
    // Load/store command, 26 bits
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        ldst_op_e                        op;
        logic [`LDST_SDRAM_ADDR_W-1:0]   sdram_addr;  // First line, byte address
        logic [`LDST_RF_ADDR_W-1:0]      rf_row;      // First RF row
        logic [`LDST_CNT_W-1:0]          line_cnt;    // Nonzero
    } ldst_cmd_t;

endpackage

//--- ldst_defs.svh
// Sizes for the line mover; the RF row wraps after LDST_RF_ROWS, with no bounds check
`ifndef LDST_DEFS_SVH
`define LDST_DEFS_SVH

////////////////////////////////////////////////////////////
// Beat and line geometry
////////////////////////////////////////////////////////////
`define LDST_BEAT_W        32
`define LDST_BEATS         4
`define LDST_LINE_W        128   // LDST_BEAT_W * LDST_BEATS

////////////////////////////////////////////////////////////
// Address spaces
////////////////////////////////////////////////////////////
`define LDST_RF_ROWS       16
`define LDST_RF_ADDR_W     4
`define LDST_SDRAM_ADDR_W  16    // Byte address
`define LDST_LINE_STRIDE   16    // Bytes per line in SDRAM
`define LDST_CNT_W         5     // Holds 1 to 16 lines

`endif
